// ==== run_sim.sh ====
#!/bin/sh
# compile with Verilator, run, and judge the run from its log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_test_station \
  -f test_station.f -o sim_test_station || exit 1
./obj_dir/sim_test_station > sim.log 2>&1
cat sim.log
grep -q "sim failed" sim.log && echo "FAIL" && exit 1
grep -q "sim passed" sim.log || { echo "FAIL: run ended without a pass line"; exit 1; }
echo "PASS"

// ==== test_station.f ====
verilog/station_pkg.sv
verilog/sram_write_if.sv
verilog/adc_capture.sv
verilog/vector_tester.sv
verilog/sram_write_arb.sv
verilog/test_station.sv
verification/test_station_assertions.sv
verification/tb_test_station.sv

// ==== verification/tb_test_station.sv ====
`timescale 1ns/100ps

module tb_test_station;

  typedef logic [station_pkg::ADDR_WIDTH-1:0] addr_t;
  typedef logic [station_pkg::DATA_WIDTH-1:0] data_t;
  typedef logic [station_pkg::ADC_WIDTH-1:0] sample_t;

  // all tests together take roughly 400 cycles
  localparam int CYCLE_LIMIT = 2000;
  localparam int ADC_DONE_LIMIT = 4;
  localparam int TR_DONE_LIMIT = station_pkg::VECTOR_COUNT * (station_pkg::SETTLE_CYCLES + 4);
  localparam addr_t TESTER_END = station_pkg::TESTER_BASE + addr_t'(station_pkg::VECTOR_COUNT);

  logic clock;
  logic rst_n;
  logic adc_enable;
  logic adc_valid;
  sample_t adc_data;
  logic tr_enable;
  logic adc_pwrdwn;
  logic adc_done;
  logic tr_done;
  logic [station_pkg::PIN_WIDTH-1:0] dut_a;
  logic [station_pkg::PIN_WIDTH-1:0] dut_q;
  addr_t sram_addr;
  data_t sram_dq;
  logic sram_we_n;
  logic sram_ce_n;

  logic [31:0] lfsr = 32'hbe14_4eee;
  data_t sram_mem [addr_t];
  sample_t sent [2*station_pkg::ADC_WORDS];
  int cycle_count = 0;
  int tester_writes = 0;
  int tr_done_count = 0;

  test_station i_dut (.*);

  bind test_station test_station_assertions i_assertions (
    .clock           (clock),
    .rst_n           (rst_n),
    .sram_we_n       (sram_we_n),
    .sram_ce_n       (sram_ce_n),
    .adc_waitrequest (adc_bus.waitrequest),
    .tr_write        (tester_bus.write),
    .tr_waitrequest  (tester_bus.waitrequest),
    .tr_address      (tester_bus.address),
    .tr_writedata    (tester_bus.writedata)
  );

  always #2 clock = ~clock;

  // device under test answers with its stimulus moved up one pin
  assign dut_q = dut_a << 1;

  // SRAM model that also counts tester writes and done pulses
  always @(posedge clock) begin
    if (!sram_we_n) begin
      sram_mem[sram_addr] = sram_dq;
      if (sram_addr >= station_pkg::TESTER_BASE && sram_addr < TESTER_END) begin
        tester_writes++;
      end
    end
    if (tr_done) begin
      tr_done_count++;
    end
  end

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("timeout after %0d clock cycles, a test never finished", CYCLE_LIMIT);
      abort_run();
    end
  end

  task automatic abort_run();
    $display("sim failed");
    $fatal(1, "run stopped on first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
      abort_run();
    end
  endtask

  task automatic check_word(input addr_t addr, input data_t expected);
    if (!sram_mem.exists(addr)) begin
      $display("no SRAM write ever reached address %h", addr);
      abort_run();
    end
    check_value($sformatf("sram[%h]", addr), 32'(sram_mem[addr]), 32'(expected));
  endtask

  // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
  function automatic logic [31:0] random_bits(input int bits);
    logic [31:0] value;
    value = '0;
    for (int b = 0; b < bits; b++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      value = {value[30:0], lfsr[0]};
    end
    return value;
  endfunction

  // inputs change 1 ns after each rising edge
  task automatic step();
    @(posedge clock);
    #1;
  endtask

  task automatic pulse_enables(input bit adc_start, input bit tr_start);
    adc_enable = adc_start;
    tr_enable = tr_start;
    step();
    adc_enable = 1'b0;
    tr_enable = 1'b0;
  endtask

  task automatic wait_done(input bit tester_side, input string what, input int limit);
    int waited;
    bit seen;
    waited = 0;
    seen = 1'b0;
    while (!seen && waited < limit) begin
      step();
      waited++;
      seen = tester_side ? tr_done : adc_done;
    end
    if (!seen) begin
      $display("%s done pulse did not arrive within %0d cycles", what, limit);
      abort_run();
    end
    // let the last SRAM write land in the model
    repeat (2) step();
  endtask

  task automatic feed_samples(input bit spaced);
    int gap;
    for (int k = 0; k < 2*station_pkg::ADC_WORDS; k++) begin
      if (spaced && k > 0) begin
        gap = int'(random_bits(2) % 32'd3);
        repeat (gap) step();
      end
      sent[k] = sample_t'(random_bits(station_pkg::ADC_WIDTH));
      adc_valid = 1'b1;
      adc_data = sent[k];
      step();
      adc_valid = 1'b0;
    end
  endtask

  // later sample in the high byte
  task automatic check_capture();
    for (int k = 0; k < station_pkg::ADC_WORDS; k++) begin
      check_word(station_pkg::ADC_BASE + addr_t'(k), {sent[2*k+1], sent[2*k]});
    end
    check_value("adc_pwrdwn", 32'(adc_pwrdwn), 32'h1);
  endtask

  task automatic check_vectors();
    logic [31:0] walking;
    for (int i = 0; i < station_pkg::VECTOR_COUNT; i++) begin
      walking = 32'h1 << (i + 1);
      check_word(station_pkg::TESTER_BASE + addr_t'(i), walking[15:0]);
    end
    check_value("dut_a", 32'(dut_a), 32'h0);
  endtask

  task automatic test_reset_state();
    check_value("adc_pwrdwn", 32'(adc_pwrdwn), 32'h1);
    check_value("sram_we_n", 32'(sram_we_n), 32'h1);
    check_value("sram_ce_n", 32'(sram_ce_n), 32'h1);
    check_value("sram_addr", 32'(sram_addr), 32'h0);
    check_value("sram_dq", 32'(sram_dq), 32'h0);
    check_value("dut_a", 32'(dut_a), 32'h0);
    check_value("adc_done", 32'(adc_done), 32'h0);
    check_value("tr_done", 32'(tr_done), 32'h0);
  endtask

  task automatic test_adc_capture();
    sram_mem.delete();
    pulse_enables(1'b1, 1'b0);
    // converter powered up once the burst is running
    check_value("adc_pwrdwn", 32'(adc_pwrdwn), 32'h0);
    feed_samples(1'b1);
    wait_done(1'b0, "ADC", ADC_DONE_LIMIT);
    check_capture();
  endtask

  task automatic test_vector_tester();
    sram_mem.delete();
    pulse_enables(1'b0, 1'b1);
    wait_done(1'b1, "tester", TR_DONE_LIMIT);
    check_vectors();
  endtask

  // ADC bursts every cycle so the tester gets held off
  task automatic test_contention();
    sram_mem.delete();
    pulse_enables(1'b1, 1'b1);
    feed_samples(1'b0);
    wait_done(1'b0, "ADC", ADC_DONE_LIMIT);
    wait_done(1'b1, "tester", TR_DONE_LIMIT);
    check_capture();
    check_vectors();
  endtask

  task automatic test_enable_while_busy();
    sram_mem.delete();
    tester_writes = 0;
    tr_done_count = 0;
    pulse_enables(1'b0, 1'b1);
    repeat (20) step();
    pulse_enables(1'b0, 1'b1);
    wait_done(1'b1, "tester", TR_DONE_LIMIT);
    repeat (2 * (station_pkg::SETTLE_CYCLES + 2)) step();
    check_value("tester_writes", 32'(tester_writes), 32'(station_pkg::VECTOR_COUNT));
    check_value("tr_done_count", 32'(tr_done_count), 32'h1);
    check_vectors();
  endtask

  initial begin
    clock = 1'b0;
    rst_n = 1'b0;
    adc_enable = 1'b0;
    adc_valid = 1'b0;
    adc_data = '0;
    tr_enable = 1'b0;
    repeat (3) @(posedge clock);
    #1;
    rst_n = 1'b1;
    test_reset_state();
    test_adc_capture();
    test_vector_tester();
    test_contention();
    test_enable_while_busy();
    $display("sim passed");
    $finish;
  end

endmodule

// ==== verification/test_station_assertions.sv ====
`timescale 1ns/100ps

module test_station_assertions (
  input logic clock,
  input logic rst_n,
  input logic sram_we_n,
  input logic sram_ce_n,
  input logic adc_waitrequest,
  input logic tr_write,
  input logic tr_waitrequest,
  input logic [station_pkg::ADDR_WIDTH-1:0] tr_address,
  input logic [station_pkg::DATA_WIDTH-1:0] tr_writedata
);

  // chip enable is the write strobe
  ce_matches_we: assert property (@(posedge clock) disable iff (!rst_n)
    sram_ce_n == sram_we_n)
    else $error("sram_ce_n differs from sram_we_n");

  // ADC side always wins arbitration
  adc_never_held: assert property (@(posedge clock) disable iff (!rst_n)
    !adc_waitrequest)
    else $error("ADC write was held off by the arbiter");

  tester_held_stable: assert property (@(posedge clock) disable iff (!rst_n)
    tr_write && tr_waitrequest |=> $stable(tr_address) && $stable(tr_writedata))
    else $error("tester changed address or data while its write was stalled");

endmodule

// ==== verilog/adc_capture.sv ====
`timescale 1ns/100ps

module adc_capture (
  input  logic clock,
  input  logic rst_n,
  input  logic enable,
  input  logic adc_valid,
  input  logic [station_pkg::ADC_WIDTH-1:0] adc_data,
  output logic adc_pwrdwn,
  output logic done,
  sram_write_if.master mem
);

  logic busy;
  logic have_first;
  logic accept;
  logic pair_ready;
  logic [station_pkg::ADC_IDX_WIDTH-1:0] word_cnt;
  logic [station_pkg::ADC_WIDTH-1:0] first_sample;

  assign accept = mem.write && !mem.waitrequest;
  // second sample of a pair arriving
  assign pair_ready = busy && adc_valid && have_first;

  // converter only powered while a burst runs
  assign adc_pwrdwn = !busy;

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      busy <= 1'b0;
      have_first <= 1'b0;
      word_cnt <= '0;
      mem.write <= 1'b0;
      done <= 1'b0;
    end else begin
      done <= 1'b0;
      if (!busy) begin
        if (enable) begin
          busy <= 1'b1;
          have_first <= 1'b0;
          word_cnt <= '0;
        end
      end else begin
        if (adc_valid) begin
          have_first <= !have_first;
        end
        if (pair_ready) begin
          mem.write <= 1'b1;
        end else if (accept) begin
          mem.write <= 1'b0;
        end
        if (accept) begin
          word_cnt <= word_cnt + 1'b1;
          // last word written, back to power down
          if (word_cnt == station_pkg::ADC_LAST) begin
            busy <= 1'b0;
            done <= 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (busy && adc_valid && !have_first) begin
      first_sample <= adc_data;
    end
    if (pair_ready) begin
      mem.writedata.sample[1] <= adc_data;
      mem.writedata.sample[0] <= first_sample;
      mem.address <= station_pkg::ADC_BASE +
                     {{(station_pkg::ADDR_WIDTH - $bits(word_cnt)){1'b0}}, word_cnt};
    end
  end

endmodule

// ==== verilog/sram_write_arb.sv ====
`timescale 1ns/100ps

module sram_write_arb (
  input  logic clock,
  input  logic rst_n,
  sram_write_if.arbiter adc,
  sram_write_if.arbiter tester,
  output logic [station_pkg::ADDR_WIDTH-1:0] sram_addr,
  output logic [station_pkg::DATA_WIDTH-1:0] sram_dq,
  output logic sram_we_n,
  output logic sram_ce_n
);

  logic adc_grant;
  logic tr_grant;
  logic strobe_n;

  // adc has fixed priority
  assign adc_grant = adc.write;
  assign tr_grant = tester.write && !adc.write;

  // loser is held off for the cycle
  assign adc.waitrequest = 1'b0;
  assign tester.waitrequest = tester.write && adc_grant;

  // chip enable follows the write strobe
  assign sram_we_n = strobe_n;
  assign sram_ce_n = strobe_n;

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      sram_addr <= '0;
      sram_dq <= '0;
      strobe_n <= 1'b1;
    end else begin
      if (adc_grant) begin
        sram_addr <= adc.address;
        sram_dq <= adc.writedata.raw;
        strobe_n <= 1'b0;
      end else if (tr_grant) begin
        sram_addr <= tester.address;
        sram_dq <= tester.writedata.raw;
        strobe_n <= 1'b0;
      end else begin
        // address and data left as they were
        strobe_n <= 1'b1;
      end
    end
  end

endmodule

// ==== verilog/sram_write_if.sv ====
`timescale 1ns/100ps

interface sram_write_if;

  logic [station_pkg::ADDR_WIDTH-1:0] address;
  logic write;
  station_pkg::sram_word_u writedata;
  logic waitrequest;

  // write taken on a rising edge with write high and waitrequest low
  modport master (
    output address,
    output write,
    output writedata,
    input  waitrequest
  );

  modport arbiter (
    input  address,
    input  write,
    input  writedata,
    output waitrequest
  );

endinterface

// ==== verilog/station_pkg.sv ====
package station_pkg;

  // SRAM geometry
  localparam int ADDR_WIDTH = 20;
  localparam int DATA_WIDTH = 16;

  // ADC sample and DUT pin widths
  localparam int ADC_WIDTH = 8;
  localparam int PIN_WIDTH = 24;

  // capture burst, two samples per word
  localparam int ADC_WORDS = 8;
  localparam logic [ADDR_WIDTH-1:0] ADC_BASE = 20'h0_0000;

  // vector tester run
  localparam logic [ADDR_WIDTH-1:0] TESTER_BASE = 20'h0_1000;
  localparam int VECTOR_COUNT = 16;
  localparam int SETTLE_CYCLES = 4;

  // counter widths derived from the counts above
  localparam int ADC_IDX_WIDTH = $clog2(ADC_WORDS);
  localparam int VEC_IDX_WIDTH = $clog2(VECTOR_COUNT);
  localparam int SETTLE_WIDTH = $clog2(SETTLE_CYCLES);

  // terminal counter values
  localparam logic [ADC_IDX_WIDTH-1:0] ADC_LAST = ADC_IDX_WIDTH'(ADC_WORDS - 1);
  localparam logic [VEC_IDX_WIDTH-1:0] VEC_LAST = VEC_IDX_WIDTH'(VECTOR_COUNT - 1);
  localparam logic [SETTLE_WIDTH-1:0] SETTLE_LOAD = SETTLE_WIDTH'(SETTLE_CYCLES - 1);

  // one SRAM word, either raw or as a sample pair
  // sample[1] is the later sample, sample[0] the earlier one
  typedef union packed {
    logic [DATA_WIDTH-1:0] raw;
    logic [1:0][ADC_WIDTH-1:0] sample;
  } sram_word_u;

endpackage

// ==== verilog/test_station.sv ====
`timescale 1ns/100ps

module test_station (
  input  logic clock,
  input  logic rst_n,

  // ADC
  input  logic adc_enable,
  input  logic adc_valid,
  input  logic [station_pkg::ADC_WIDTH-1:0] adc_data,
  output logic adc_pwrdwn,
  output logic adc_done,

  // DUT
  input  logic tr_enable,
  output logic tr_done,
  output logic [station_pkg::PIN_WIDTH-1:0] dut_a,
  input  logic [station_pkg::PIN_WIDTH-1:0] dut_q,

  // SRAM
  output logic [station_pkg::ADDR_WIDTH-1:0] sram_addr,
  output logic [station_pkg::DATA_WIDTH-1:0] sram_dq,
  output logic sram_we_n,
  output logic sram_ce_n
);

  sram_write_if adc_bus ();
  sram_write_if tester_bus ();

  adc_capture adc (
    .clock      (clock),
    .rst_n      (rst_n),
    .enable     (adc_enable),
    .adc_valid  (adc_valid),
    .adc_data   (adc_data),
    .adc_pwrdwn (adc_pwrdwn),
    .done       (adc_done),
    .mem        (adc_bus.master)
  );

  vector_tester tester (
    .clock      (clock),
    .rst_n      (rst_n),
    .enable     (tr_enable),
    .dut_a      (dut_a),
    .dut_q      (dut_q),
    .done       (tr_done),
    .mem        (tester_bus.master)
  );

  sram_write_arb sram_arb (
    .clock      (clock),
    .rst_n      (rst_n),
    .adc        (adc_bus.arbiter),
    .tester     (tester_bus.arbiter),
    .sram_addr  (sram_addr),
    .sram_dq    (sram_dq),
    .sram_we_n  (sram_we_n),
    .sram_ce_n  (sram_ce_n)
  );

endmodule

// ==== verilog/vector_tester.sv ====
`timescale 1ns/100ps

module vector_tester (
  input  logic clock,
  input  logic rst_n,
  input  logic enable,
  output logic [station_pkg::PIN_WIDTH-1:0] dut_a,
  input  logic [station_pkg::PIN_WIDTH-1:0] dut_q,
  output logic done,
  sram_write_if.master mem
);

  logic busy;
  logic accept;
  logic sample_now;
  logic [station_pkg::SETTLE_WIDTH-1:0] settle_cnt;
  logic [station_pkg::VEC_IDX_WIDTH-1:0] vec_idx;
  logic [station_pkg::VEC_IDX_WIDTH-1:0] next_idx;

  assign accept = mem.write && !mem.waitrequest;
  assign next_idx = vec_idx + 1'b1;

  // settle phase is busy with no write pending
  assign sample_now = busy && !mem.write && (settle_cnt == '0);

  // drive -> settle -> write, per vector
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      busy <= 1'b0;
      mem.write <= 1'b0;
      settle_cnt <= '0;
      vec_idx <= '0;
      dut_a <= '0;
      done <= 1'b0;
    end else begin
      done <= 1'b0;
      if (!busy) begin
        if (enable) begin
          busy <= 1'b1;
          vec_idx <= '0;
          dut_a <= {{(station_pkg::PIN_WIDTH - 1){1'b0}}, 1'b1};
          settle_cnt <= station_pkg::SETTLE_LOAD;
        end
      end else if (mem.write) begin
        // stall here while the arbiter holds us off
        if (accept) begin
          mem.write <= 1'b0;
          if (vec_idx == station_pkg::VEC_LAST) begin
            busy <= 1'b0;
            dut_a <= '0;
            done <= 1'b1;
          end else begin
            vec_idx <= next_idx;
            dut_a <= {{(station_pkg::PIN_WIDTH - 1){1'b0}}, 1'b1} << next_idx;
            settle_cnt <= station_pkg::SETTLE_LOAD;
          end
        end
      end else if (sample_now) begin
        mem.write <= 1'b1;
      end else begin
        settle_cnt <= settle_cnt - 1'b1;
      end
    end
  end

  // response captured once the pins have settled
  always_ff @(posedge clock) begin
    if (sample_now) begin
      mem.writedata.raw <= dut_q[station_pkg::DATA_WIDTH-1:0];
      mem.address <= station_pkg::TESTER_BASE +
                     {{(station_pkg::ADDR_WIDTH - $bits(vec_idx)){1'b0}}, vec_idx};
    end
  end

endmodule
